/* design/tdc_spi_config.svh */
`ifndef TDC_SPI_CONFIG_SVH
`define TDC_SPI_CONFIG_SVH

// one sck period is 2**TDC_SPI_CLK_DIV clk cycles
`define TDC_SPI_CLK_DIV 2

// apb address width in bits
`define TDC_APB_ADDR_W 4

// register byte offsets
`define TDC_REG_CMD    4'h0   // host writes the tx byte and cs_end
`define TDC_REG_STATUS 4'h4   // host reads busy, done, overrun and cs
`define TDC_REG_RXDATA 4'h8   // host reads the last received byte

// bit positions inside the register words
`define TDC_CMD_CS_END_BIT 8

`endif

/* design/tdc_spi_pkg.sv */
`default_nettype none

`include "tdc_spi_config.svh"

package tdc_spi_pkg;

  typedef logic [7:0] spi_byte_t;                        // one spi data byte
  typedef logic [`TDC_APB_ADDR_W-1:0] apb_addr_t;        // apb byte address
  typedef logic [31:0] apb_data_t;                       // apb read / write word
  typedef logic [`TDC_SPI_CLK_DIV-1:0] spi_phase_t;      // sck phase counter

  // byte engine states
  // cs goes low on leaving idle and takes its new level in wait_before_cs
  typedef enum logic [2:0] {
    idle,
    wait_half,        // half period between cs low and the first bit
    transfer,         // eight bit periods, sck toggling
    wait_before_cs,   // half period, then cs takes the cs_end level
    wait_during_cs    // one full period of hold
  } spi_state_t;

endpackage

`default_nettype wire

/* design/spi_cmd_if.sv */
`timescale 1ns/100ps
`default_nettype none

interface spi_cmd_if;
  import tdc_spi_pkg::*;

  logic      start;     // one cycle launch pulse
  spi_byte_t tx_data;
  logic      cs_end;    // release cs after this byte
  logic      rd_rx;     // rxdata was read
  logic      busy;
  logic      cs;        // cs pin level, active low
  spi_byte_t rx_byte;   // byte shifted in by the engine
  logic      new_data;  // rx_byte valid, one cycle
  spi_byte_t rx_data;   // holding register seen by the host
  logic      done;
  logic      overrun;

  modport decoder (
    output start, tx_data, cs_end, rd_rx,
    input  busy, cs, rx_data, done, overrun
  );

  modport engine (
    input  start, tx_data, cs_end,
    output busy, cs, rx_byte, new_data
  );

  modport result (
    input  new_data, rx_byte, rd_rx,
    output rx_data, done, overrun
  );

endinterface

`default_nettype wire

/* design/tdc_apb_decode.sv */
`timescale 1ns/100ps
`default_nettype none

`include "tdc_spi_config.svh"

module tdc_apb_decode (
  input  wire logic                   clk,
  input  wire logic                   rst,
  input  wire tdc_spi_pkg::apb_addr_t paddr,
  input  wire logic                   psel,
  input  wire logic                   penable,
  input  wire logic                   pwrite,
  input  wire tdc_spi_pkg::apb_data_t pwdata,
  output      tdc_spi_pkg::apb_data_t prdata,
  output      logic                   pready,
  output      logic                   pslverr,
  spi_cmd_if.decoder                  cmd
);
  import tdc_spi_pkg::*;

  logic      access;      // apb access phase
  logic      hit_cmd;
  logic      hit_status;
  logic      hit_rxdata;
  logic      mapped;
  logic      wr_cmd;
  logic      cmd_stall;
  logic      cmd_done;    // cmd write completes this cycle
  logic      rd_en;
  logic      start_q;
  spi_byte_t tx_data_q;
  logic      cs_end_q;
  apb_data_t status_word;

  assign access     = psel && penable;
  assign hit_cmd    = (paddr == `TDC_REG_CMD);
  assign hit_status = (paddr == `TDC_REG_STATUS);
  assign hit_rxdata = (paddr == `TDC_REG_RXDATA);
  assign mapped     = hit_cmd || hit_status || hit_rxdata;

  // a cmd write has to wait until the engine has taken the previous one,
  // start_q covers the cycle before busy rises
  assign wr_cmd    = access && pwrite && hit_cmd;
  assign cmd_stall = wr_cmd && (cmd.busy || start_q);
  assign cmd_done  = wr_cmd && !cmd_stall;

  assign pready  = !cmd_stall;         // only back-pressure on the bus
  assign pslverr = access && !mapped;

  always_ff @(posedge clk) begin
    if (rst) begin
      start_q <= 1'b0;
    end else begin
      start_q <= cmd_done;             // pulse in the cycle after completion
    end
  end

  // command payload, held stable while the engine runs
  always_ff @(posedge clk) begin
    if (cmd_done) begin
      tx_data_q <= pwdata[7:0];
      cs_end_q  <= pwdata[`TDC_CMD_CS_END_BIT];
    end
  end

  assign cmd.start   = start_q;
  assign cmd.tx_data = tx_data_q;
  assign cmd.cs_end  = cs_end_q;

  assign status_word = {28'd0, cmd.cs, cmd.overrun, cmd.done, cmd.busy};

  // reads never stall, so the access phase lasts one cycle
  assign rd_en     = access && !pwrite;
  assign cmd.rd_rx = rd_en && hit_rxdata;

  always_comb begin
    prdata = '0;
    if (rd_en) begin
      case (paddr)
        `TDC_REG_STATUS: prdata = status_word;
        `TDC_REG_RXDATA: prdata = {24'd0, cmd.rx_data};
        default:         prdata = '0;   // cmd is write only
      endcase
    end
  end

endmodule

`default_nettype wire

/* design/tdc_spi_master.sv */
`timescale 1ns/100ps
`default_nettype none

`include "tdc_spi_config.svh"

module tdc_spi_master (
  input  wire logic  clk,
  input  wire logic  rst,
  input  wire logic  miso,
  output      logic  sck,
  output      logic  mosi,
  spi_cmd_if.engine  cmd
);
  import tdc_spi_pkg::*;

  // last phase count of a half and of a full sck period
  localparam spi_phase_t HALF_LAST = spi_phase_t'((1 << (`TDC_SPI_CLK_DIV - 1)) - 1);
  localparam spi_phase_t FULL_LAST = '1;

  spi_state_t state_d, state_q;
  spi_phase_t phase_d, phase_q;
  logic [4:0] bit_cnt_d, bit_cnt_q;
  spi_byte_t  shift_d, shift_q;     // tx bits out, rx bits in
  spi_byte_t  rx_d, rx_q;
  logic       mosi_d, mosi_q;
  logic       cs_d, cs_q;
  logic       new_data_d, new_data_q;

  // mode 0, sck idles low and rises at mid period
  assign sck  = phase_q[`TDC_SPI_CLK_DIV-1] && (state_q == transfer);
  assign mosi = mosi_q;

  assign cmd.busy     = (state_q != idle);
  assign cmd.cs       = cs_q;
  assign cmd.rx_byte  = rx_q;
  assign cmd.new_data = new_data_q;

  always_comb begin
    state_d    = state_q;
    phase_d    = phase_q;
    bit_cnt_d  = bit_cnt_q;
    shift_d    = shift_q;
    rx_d       = rx_q;
    mosi_d     = mosi_q;
    cs_d       = cs_q;
    new_data_d = 1'b0;

    case (state_q)
      idle: begin
        phase_d   = '0;
        bit_cnt_d = '0;
        if (cmd.start) begin
          state_d = wait_half;
          cs_d    = 1'b0;                  // open or continue the frame
        end
      end

      wait_half: begin
        phase_d = phase_q + 1'b1;
        if (phase_q == HALF_LAST) begin
          phase_d = '0;
          shift_d = cmd.tx_data;           // load the byte to send
          state_d = transfer;
        end
      end

      transfer: begin
        phase_d = phase_q + 1'b1;
        if (phase_q == '0) begin
          mosi_d = shift_q[7];             // msb first, sck is low here
        end else if (phase_q == HALF_LAST) begin
          shift_d = {shift_q[6:0], miso};  // sampled on the rising sck edge
        end else if (phase_q == FULL_LAST) begin
          bit_cnt_d = bit_cnt_q + 1'b1;
          if (bit_cnt_q == 5'd7) begin
            rx_d    = shift_q;             // all eight bits are in
            phase_d = '0;
            state_d = wait_before_cs;
          end
        end
      end

      wait_before_cs: begin
        phase_d = phase_q + 1'b1;
        if (phase_q == HALF_LAST) begin
          cs_d    = cmd.cs_end;            // high ends the frame
          phase_d = '0;
          state_d = wait_during_cs;
        end
      end

      wait_during_cs: begin
        phase_d = phase_q + 1'b1;
        if (phase_q == FULL_LAST) begin
          phase_d    = '0;
          new_data_d = 1'b1;               // busy drops in the same cycle
          state_d    = idle;
        end
      end

      default: state_d = idle;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q    <= idle;
      phase_q    <= '0;
      bit_cnt_q  <= '0;
      mosi_q     <= 1'b0;
      cs_q       <= 1'b1;                  // no slave selected
      new_data_q <= 1'b0;
    end else begin
      state_q    <= state_d;
      phase_q    <= phase_d;
      bit_cnt_q  <= bit_cnt_d;
      mosi_q     <= mosi_d;
      cs_q       <= cs_d;
      new_data_q <= new_data_d;
    end
  end

  always_ff @(posedge clk) begin
    shift_q <= shift_d;
    rx_q    <= rx_d;
  end

endmodule

`default_nettype wire

/* design/tdc_spi_result.sv */
`timescale 1ns/100ps
`default_nettype none

module tdc_spi_result (
  input  wire logic clk,
  input  wire logic rst,
  spi_cmd_if.result res
);
  import tdc_spi_pkg::*;

  spi_byte_t rx_data_q;
  logic      done_q;
  logic      overrun_q;

  // flags are sticky until the host reads rxdata
  always_ff @(posedge clk) begin
    if (rst) begin
      done_q    <= 1'b0;
      overrun_q <= 1'b0;
    end else if (res.new_data) begin
      done_q <= 1'b1;
      if (res.rd_rx) begin
        overrun_q <= 1'b0;                 // old byte was just read
      end else begin
        overrun_q <= overrun_q || done_q;  // unread byte gets replaced
      end
    end else if (res.rd_rx) begin
      done_q    <= 1'b0;
      overrun_q <= 1'b0;
    end
  end

  // newest byte always replaces the held one
  always_ff @(posedge clk) begin
    if (res.new_data) begin
      rx_data_q <= res.rx_byte;
    end
  end

  assign res.rx_data = rx_data_q;
  assign res.done    = done_q;
  assign res.overrun = overrun_q;

endmodule

`default_nettype wire

/* design/tdc_spi_top.sv */
`timescale 1ns/100ps
`default_nettype none

module tdc_spi_top (
  input  wire logic                   clk,
  input  wire logic                   rst,
  // apb slave
  input  wire tdc_spi_pkg::apb_addr_t paddr,
  input  wire logic                   psel,
  input  wire logic                   penable,
  input  wire logic                   pwrite,
  input  wire tdc_spi_pkg::apb_data_t pwdata,
  output      tdc_spi_pkg::apb_data_t prdata,
  output      logic                   pready,
  output      logic                   pslverr,
  // spi master pins
  output      logic                   sck,
  output      logic                   mosi,
  input  wire logic                   miso,
  output      logic                   cs        // active low
);

  spi_cmd_if cmd_bus ();

  tdc_apb_decode u_decode (
    .clk     (clk),
    .rst     (rst),
    .paddr   (paddr),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .pwdata  (pwdata),
    .prdata  (prdata),
    .pready  (pready),
    .pslverr (pslverr),
    .cmd     (cmd_bus.decoder)
  );

  tdc_spi_master u_master (
    .clk  (clk),
    .rst  (rst),
    .miso (miso),
    .sck  (sck),
    .mosi (mosi),
    .cmd  (cmd_bus.engine)
  );

  tdc_spi_result u_result (
    .clk (clk),
    .rst (rst),
    .res (cmd_bus.result)
  );

  assign cs = cmd_bus.cs;   // engine register drives the pin

endmodule

`default_nettype wire

/* tests/spi_slave_model.sv */
`timescale 1ns/100ps
`default_nettype none

// behavioral mode 0 slave, cs active low
module spi_slave_model (
  input  wire logic       sck,
  input  wire logic       mosi,
  input  wire logic       cs,
  input  wire logic [7:0] reply,   // byte returned in the next transfer
  output      logic       miso
);

  logic [2:0] bit_cnt;
  logic [7:0] in_sr;
  logic [7:0] out_sr;             // copy of reply taken on the first rising edge
  logic [7:0] rx_log [0:63];      // received bytes in arrival order
  int         byte_cnt;
  int         frame_cnt;

  initial begin
    bit_cnt   = '0;
    in_sr     = '0;
    out_sr    = '0;
    byte_cnt  = 0;
    frame_cnt = 0;
  end

  // the msb has to be on miso before the first rising edge
  assign miso = (cs !== 1'b0) ? 1'b0 :
                (bit_cnt == 3'd0) ? reply[7] : out_sr[3'd7 - bit_cnt];

  always @(negedge cs) begin
    frame_cnt <= frame_cnt + 1;
  end

  always @(posedge sck) begin
    if (cs === 1'b0) begin
      if (bit_cnt == 3'd0) out_sr <= reply;
      in_sr <= {in_sr[6:0], mosi};
      if (bit_cnt == 3'd7) begin
        rx_log[byte_cnt[5:0]] <= {in_sr[6:0], mosi};
        byte_cnt              <= byte_cnt + 1;
      end
    end
  end

  // data moves on the falling edge, cs high restarts the byte
  always @(negedge sck or posedge cs) begin
    if (cs !== 1'b0) bit_cnt <= '0;
    else bit_cnt <= bit_cnt + 1'b1;
  end

endmodule

`default_nettype wire

/* tests/tdc_spi_tb.sv */
`timescale 1ns/100ps
`default_nettype none

`include "tdc_spi_config.svh"

module tdc_spi_tb;
  import tdc_spi_pkg::*;

  localparam int APB_TIMEOUT  = 16 << `TDC_SPI_CLK_DIV;  // clk cycles
  localparam int POLL_TIMEOUT = 12 << `TDC_SPI_CLK_DIV;  // status reads
  localparam int MAX_LINES    = 64;

  logic      clk;
  logic      rst;
  apb_addr_t paddr;
  logic      psel;
  logic      penable;
  logic      pwrite;
  apb_data_t pwdata;
  apb_data_t prdata;
  logic      pready;
  logic      pslverr;
  logic      sck;
  logic      mosi;
  logic      miso;
  logic      cs;
  spi_byte_t reply;

  int          err_cnt;
  int          timeout_cnt;
  logic [31:0] rnd;
  spi_byte_t   tr_tx     [0:MAX_LINES-1];
  spi_byte_t   tr_reply  [0:MAX_LINES-1];
  bit          tr_cs_end [0:MAX_LINES-1];
  bit          tr_back   [0:MAX_LINES-1];
  int          n_lines;

  tdc_spi_top u_tdc_spi_top (
    .clk (clk), .rst (rst), .paddr (paddr), .psel (psel), .penable (penable),
    .pwrite (pwrite), .pwdata (pwdata), .prdata (prdata), .pready (pready),
    .pslverr (pslverr), .sck (sck), .mosi (mosi), .miso (miso), .cs (cs)
  );

  spi_slave_model u_slave (.sck (sck), .mosi (mosi), .cs (cs), .reply (reply), .miso (miso));

  always #50 clk = ~clk;

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic check(input bit ok, input string what);
    assert (ok) else begin
      err_cnt++;
      $display("Fail at %0t ns: %s", $time, what);
    end
  endtask

  // inputs change on the falling edge and outputs are sampled 1 ns later
  task automatic apb_access(input apb_addr_t addr, input bit write, input apb_data_t wdata,
                            output apb_data_t rdata, output bit err, output int waits);
    waits = 0;
    @(negedge clk);
    paddr   = addr;
    pwrite  = write;
    pwdata  = wdata;
    psel    = 1'b1;
    penable = 1'b0;
    @(negedge clk);
    penable = 1'b1;
    #1;
    while (!pready && waits < APB_TIMEOUT) begin
      @(negedge clk);
      #1;
      waits++;
    end
    if (!pready) begin
      timeout_cnt++;
      $display("APB access to offset %h never completed, pready stayed low", addr);
    end
    rdata = prdata;
    err   = pslverr;
    @(negedge clk);  // completing edge has passed
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  task automatic reg_read(input apb_addr_t addr, output apb_data_t data, output bit err);
    int waits;
    apb_access(addr, 1'b0, '0, data, err, waits);
  endtask

  task automatic reg_write(input apb_addr_t addr, input apb_data_t data,
                           output bit err, output int waits);
    apb_data_t unused;
    apb_access(addr, 1'b1, data, unused, err, waits);
  endtask

  task automatic wait_idle(output apb_data_t status);
    bit err;
    int polls;
    polls = 0;
    reg_read(`TDC_REG_STATUS, status, err);
    while (status[0] && polls < POLL_TIMEOUT) begin
      reg_read(`TDC_REG_STATUS, status, err);
      polls++;
    end
    if (status[0]) begin
      timeout_cnt++;
      $display("engine still busy after %0d status polls", polls);
    end
  endtask

  // by then the slave has taken the reply of the running byte
  task automatic wait_sck_high();
    int n;
    n = 0;
    @(negedge clk);
    while (sck !== 1'b1 && n < APB_TIMEOUT) begin
      @(negedge clk);
      n++;
    end
    if (sck !== 1'b1) begin
      timeout_cnt++;
      $display("sck never went high during the running transfer");
    end
  endtask

  initial begin
    int        fd;
    string     line;
    spi_byte_t tx;
    spi_byte_t rep;
    int        cs_end_v;
    int        back_v;
    apb_data_t status;
    apb_data_t data;
    bit        err;
    int        waits;
    int        frames;
    int        checked;
    bit        prev_cs_end;

    clk = 1'b0;
    rst = 1'b1;
    paddr = '0;
    psel = 1'b0;
    penable = 1'b0;
    pwrite = 1'b0;
    pwdata = '0;
    reply = '0;
    err_cnt = 0;
    timeout_cnt = 0;
    rnd = 32'd83163;
    n_lines = 0;

    fd = $fopen("tests/tdc_spi_trace.txt", "r");
    if (fd == 0) begin
      err_cnt++;
      $display("could not open the trace file tests/tdc_spi_trace.txt");
    end else begin
      while (!$feof(fd) && n_lines < MAX_LINES) begin
        if ($fgets(line, fd) == 0) break;
        if (line[0] == "#") continue;
        if ($sscanf(line, "%h %h %h %h", tx, cs_end_v, rep, back_v) == 4) begin
          tr_tx[n_lines]     = tx;
          tr_cs_end[n_lines] = cs_end_v[0];
          tr_reply[n_lines]  = rep;
          tr_back[n_lines]   = back_v[0];
          n_lines++;
        end
      end
      $fclose(fd);
    end
    if (n_lines == 0) begin
      err_cnt++;
      $display("the trace holds no transfers");
    end

    repeat (3) @(negedge clk);
    rst = 1'b0;

    reg_read(`TDC_REG_STATUS, status, err);
    check(status == 32'h8 && !err, $sformatf("status after reset is %h, expected 8", status));

    // unmapped offset
    reg_write(4'hc, 32'h1a5, err, waits);
    check(err, "write to offset c completed without pslverr");
    reg_read(4'hc, data, err);
    check(err, "read from offset c completed without pslverr");
    reg_read(`TDC_REG_STATUS, status, err);
    check(!status[0] && u_slave.byte_cnt == 0, "unmapped write started a transfer");

    frames = 0;
    checked = 0;
    prev_cs_end = 1'b1;
    for (int i = 0; i < n_lines; i++) begin
      rnd = xorshift(rnd);
      if (tr_back[i]) wait_sck_high();
      else repeat (rnd[1:0]) @(negedge clk);
      if (prev_cs_end) frames++;   // cs falls and a new frame opens
      prev_cs_end = tr_cs_end[i];
      reply = tr_reply[i];
      reg_write(`TDC_REG_CMD, {23'd0, tr_cs_end[i], tr_tx[i]}, err, waits);
      check(!err, $sformatf("cmd write %0d gave pslverr", i));
      if (tr_back[i]) check(waits > 0, $sformatf("cmd write %0d was not stalled while busy", i));
      if (i + 1 < n_lines && tr_back[i + 1]) continue;

      wait_idle(status);
      reg_read(`TDC_REG_STATUS, status, err);   // done lands one cycle after busy falls
      for (int k = checked; k <= i; k++) begin
        check(u_slave.rx_log[k] == tr_tx[k],
              $sformatf("slave got %h for byte %0d, expected %h", u_slave.rx_log[k], k, tr_tx[k]));
      end
      checked = i + 1;
      check(u_slave.byte_cnt == i + 1, $sformatf("slave counted %0d bytes", u_slave.byte_cnt));
      check(u_slave.frame_cnt == frames,
            $sformatf("slave saw %0d frames, expected %0d", u_slave.frame_cnt, frames));
      check(cs === tr_cs_end[i] && status[3] == tr_cs_end[i],
            $sformatf("cs is %b after byte %0d, expected %b", cs, i, tr_cs_end[i]));
      check(status[2:1] == {tr_back[i], 1'b1},
            $sformatf("done/overrun are %b after byte %0d", status[2:1], i));
      if (rnd[2]) begin
        reg_read(`TDC_REG_STATUS, status, err);
        check(status[2:1] == {tr_back[i], 1'b1}, "flags did not stay set until the rxdata read");
      end
      reg_read(`TDC_REG_RXDATA, data, err);
      check(data == {24'd0, tr_reply[i]},
            $sformatf("rxdata is %h, expected %h", data, tr_reply[i]));
      reg_read(`TDC_REG_STATUS, status, err);
      check(status[2:0] == 3'b000, $sformatf("status %h after rxdata read", status));
    end

    $display("errors: %0d failed checks, %0d timeouts", err_cnt, timeout_cnt);
    if (err_cnt == 0 && timeout_cnt == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* vlog.f */
+incdir+design
design/tdc_spi_pkg.sv
design/spi_cmd_if.sv
design/tdc_apb_decode.sv
design/tdc_spi_master.sv
design/tdc_spi_result.sv
design/tdc_spi_top.sv
tests/spi_slave_model.sv
tests/tdc_spi_tb.sv

/* Bender.yml */
package:
  name: tdc_spi

sources:
  - include_dirs:
      - design
    files:
      - design/tdc_spi_pkg.sv
      - design/spi_cmd_if.sv
      - design/tdc_apb_decode.sv
      - design/tdc_spi_master.sv
      - design/tdc_spi_result.sv
      - design/tdc_spi_top.sv
  - target: test
    include_dirs:
      - design
    files:
      - tests/spi_slave_model.sv
      - tests/tdc_spi_tb.sv

/* tests/tdc_spi_trace.txt */
# columns, all hex: tx byte, cs_end, slave reply byte, back
# back = 1 issues this command while the previous byte is still busy
a5 1 3c 0
01 0 81 0
7e 0 42 0
ff 1 00 0
00 1 ff 0
90 0 5a 0
12 0 c3 1
34 1 e7 0
c8 0 19 0
2b 1 d4 1
66 1 99 0
80 0 01 1
0f 1 f0 1
